// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and pass only if the summary line reports success
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_cpu -f verilog.f \
	&& ./obj_dir/Vtb_cpu | tee /dev/stderr | grep "^NO ERRORS$" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== src/cpu_pkg.sv ====
// Shared types and constants of the 16-bit core, referenced by scoped name from every RTL file
`default_nettype none

package cpu_pkg;

	// Data, address and instruction word
	typedef logic [15:0] word_t;

	// Index into the general register file
	typedef logic [3:0] reg_addr_t;

	// Instruction opcodes, low nibble of the instruction word
	typedef enum logic [3:0] {
		halt     = 4'h0,
		mov      = 4'h1,
		movnz    = 4'h2,
		movez    = 4'h3,
		bus      = 4'h4,
		memr     = 4'h5,
		set      = 4'h6,
		memw     = 4'h7,
		alu_and  = 4'h8,
		alu_or   = 4'h9,
		alu_xor  = 4'hA,
		alu_add  = 4'hB,
		alu_shft = 4'hC,
		alu_mul  = 4'hD,
		alu_gt   = 4'hE,
		alu_eq   = 4'hF
	} opcode_t;

	// Bit positions of the instruction fields
	localparam int op_field_lsb   = 0;
	localparam int from_field_lsb = 4;
	localparam int to_field_lsb   = 8;
	localparam int cond_field_lsb = 12;

	localparam int num_regs = 16;

	// Result of GT and EQ when the comparison holds
	localparam word_t true_word = '1;

	// Low byte of the cond operand is the shift count
	localparam int shift_amount_bits = 8;

	// Data port request, write flag in the top bit
	typedef struct packed {
		logic  write;
		word_t addr;
		word_t wdata;
	} mem_req_t;

	// Instruction sequencer states
	typedef enum logic [2:0] {
		fetch     = 3'd0,
		set_fetch = 3'd1,
		decode    = 3'd2,
		execute   = 3'd3,
		writeback = 3'd4,
		halted    = 3'd5
	} seq_state_t;

endpackage

`default_nettype wire

// ==== src/cpu_top.sv ====
// Top level of the core; connect the program fetch port and the data port to external memories
`default_nettype none

module cpu_top (
	input  logic           clk,
	input  logic           mem_read_ready_stor_reset,
	output logic           fetch_req,
	output cpu_pkg::word_t fetch_addr,
	input  logic           fetch_ack,
	input  cpu_pkg::word_t fetch_data,
	output logic           mem_req,
	output logic           mem_we,
	output cpu_pkg::word_t mem_addr,
	output cpu_pkg::word_t mem_wdata,
	input  logic           mem_ack,
	input  cpu_pkg::word_t mem_rdata,
	output logic           halted
);

	logic               exec_start;
	logic               exec_done;
	cpu_pkg::opcode_t   op;
	cpu_pkg::reg_addr_t from_sel;
	cpu_pkg::reg_addr_t to_sel;
	cpu_pkg::reg_addr_t cond_sel;
	cpu_pkg::word_t     set_value;
	cpu_pkg::word_t     operand_a;
	cpu_pkg::word_t     operand_b;
	logic               wb_en;
	cpu_pkg::word_t     wb_data;
	logic               reg_write_en;

	// Write back only in the completion cycle
	assign reg_write_en = wb_en && exec_done;

	instr_sequencer u_instr_sequencer (
		.clk                       (clk),
		.mem_read_ready_stor_reset (mem_read_ready_stor_reset),
		.fetch_req                 (fetch_req),
		.fetch_addr                (fetch_addr),
		.fetch_ack                 (fetch_ack),
		.fetch_data                (fetch_data),
		.exec_start                (exec_start),
		.op                        (op),
		.from_sel                  (from_sel),
		.to_sel                    (to_sel),
		.cond_sel                  (cond_sel),
		.set_value                 (set_value),
		.exec_done                 (exec_done),
		.halted                    (halted)
	);

	execute_unit u_execute_unit (
		.clk                       (clk),
		.mem_read_ready_stor_reset (mem_read_ready_stor_reset),
		.exec_start                (exec_start),
		.op                        (op),
		.set_value                 (set_value),
		.operand_a                 (operand_a),
		.operand_b                 (operand_b),
		.mem_req                   (mem_req),
		.mem_we                    (mem_we),
		.mem_addr                  (mem_addr),
		.mem_wdata                 (mem_wdata),
		.mem_ack                   (mem_ack),
		.mem_rdata                 (mem_rdata),
		.exec_done                 (exec_done),
		.wb_en                     (wb_en),
		.wb_data                   (wb_data)
	);

	register_file u_register_file (
		.clk                       (clk),
		.mem_read_ready_stor_reset (mem_read_ready_stor_reset),
		.read_a_sel                (from_sel),
		.read_b_sel                (cond_sel),
		.read_a                    (operand_a),
		.read_b                    (operand_b),
		.write_en                  (reg_write_en),
		.write_sel                 (to_sel),
		.write_data                (wb_data)
	);

	// Execute unit only answers while the sequencer waits for it
	a_done_in_execute: assert property (@(posedge clk) disable iff (mem_read_ready_stor_reset)
		exec_done |-> u_instr_sequencer.state == cpu_pkg::execute);

	// One instruction at a time, so the two ports never overlap
	a_ports_exclusive: assert property (@(posedge clk) disable iff (mem_read_ready_stor_reset)
		!(fetch_req && mem_req));

endmodule

`default_nettype wire

// ==== src/execute_unit.sv ====
// Execute unit: ALU, conditional move test and data memory transfer for the current instruction
`default_nettype none

module execute_unit (
	input  logic             clk,
	input  logic             mem_read_ready_stor_reset,
	input  logic             exec_start,
	input  cpu_pkg::opcode_t op,
	input  cpu_pkg::word_t   set_value,
	input  cpu_pkg::word_t   operand_a,
	input  cpu_pkg::word_t   operand_b,
	output logic             mem_req,
	output logic             mem_we,
	output cpu_pkg::word_t   mem_addr,
	output cpu_pkg::word_t   mem_wdata,
	input  logic             mem_ack,
	input  cpu_pkg::word_t   mem_rdata,
	output logic             exec_done,
	output logic             wb_en,
	output cpu_pkg::word_t   wb_data
);

	cpu_pkg::word_t    alu_result;
	logic              move_taken;
	logic              is_mem_op;
	logic              reg_op_start;
	logic              mem_start;
	logic              mem_done;
	cpu_pkg::mem_req_t mem_payload;
	cpu_pkg::mem_req_t mem_out;
	cpu_pkg::word_t    mem_response;

	assign is_mem_op    = (op == cpu_pkg::memr) || (op == cpu_pkg::memw);
	assign reg_op_start = exec_start && !is_mem_op;
	assign mem_start    = exec_start && is_mem_op;

	// Address from the from register, store data from the cond register
	always_comb begin
		mem_payload.write = (op == cpu_pkg::memw);
		mem_payload.addr  = operand_a;
		mem_payload.wdata = operand_b;
	end

	assign mem_we    = mem_out.write;
	assign mem_addr  = mem_out.addr;
	assign mem_wdata = mem_out.wdata;

	four_phase_requester #(
		.payload_t  (cpu_pkg::mem_req_t),
		.response_t (cpu_pkg::word_t)
	) u_mem_requester (
		.clk                       (clk),
		.mem_read_ready_stor_reset (mem_read_ready_stor_reset),
		.start                     (mem_start),
		.payload                   (mem_payload),
		.req                       (mem_req),
		.req_payload               (mem_out),
		.ack                       (mem_ack),
		.ack_response              (mem_rdata),
		.done                      (mem_done),
		.response                  (mem_response)
	);

	// Condition register tested against zero
	always_comb begin
		case (op)
			cpu_pkg::movnz: move_taken = |operand_b;
			cpu_pkg::movez: move_taken = ~|operand_b;
			default:        move_taken = 1'b1;
		endcase
	end

	always_comb begin
		case (op)
			cpu_pkg::set:     alu_result = set_value;
			cpu_pkg::alu_and: alu_result = operand_a & operand_b;
			cpu_pkg::alu_or:  alu_result = operand_a | operand_b;
			cpu_pkg::alu_xor: alu_result = operand_a ^ operand_b;
			cpu_pkg::alu_add: alu_result = operand_a + operand_b;
			cpu_pkg::alu_mul: alu_result = operand_a * operand_b;
			cpu_pkg::alu_gt:  alu_result = (operand_a > operand_b) ? cpu_pkg::true_word : '0;
			cpu_pkg::alu_eq:  alu_result = (operand_a == operand_b) ? cpu_pkg::true_word : '0;
			cpu_pkg::alu_shft: begin
				// Nonzero high byte means shift left
				if (|operand_b[15:cpu_pkg::shift_amount_bits]) begin
					alu_result = operand_a << operand_b[cpu_pkg::shift_amount_bits-1:0];
				end else begin
					alu_result = operand_a >> operand_b[cpu_pkg::shift_amount_bits-1:0];
				end
			end
			// Moves pass the from register
			default: alu_result = operand_a;
		endcase
	end

	always_ff @(posedge clk) begin
		if (mem_read_ready_stor_reset) begin
			exec_done <= 1'b0;
			wb_en <= 1'b0;
		end else begin
			exec_done <= reg_op_start || mem_done;
			if (reg_op_start) begin
				wb_en <= move_taken;
			end else if (mem_done) begin
				wb_en <= (op == cpu_pkg::memr);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reg_op_start) begin
			wb_data <= alu_result;
		end else if (mem_done) begin
			wb_data <= mem_response;
		end
	end

endmodule

`default_nettype wire

// ==== src/four_phase_requester.sv ====
// Generic four-phase req/ack master, instantiated once per external port with its own payload type
`default_nettype none

module four_phase_requester #(
	parameter type payload_t  = logic,
	parameter type response_t = logic
) (
	input  logic      clk,
	input  logic      mem_read_ready_stor_reset,
	input  logic      start,
	input  payload_t  payload,
	output logic      req,
	output payload_t  req_payload,
	input  logic      ack,
	input  response_t ack_response,
	output logic      done,
	output response_t response
);

	// High from start until the responder has dropped ack
	logic busy;

	always_ff @(posedge clk) begin
		if (mem_read_ready_stor_reset) begin
			busy <= 1'b0;
			req <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (!busy) begin
				if (start) begin
					busy <= 1'b1;
					req <= 1'b1;
				end
			end else if (req) begin
				// Responder answered, release the request
				if (ack) begin
					req <= 1'b0;
				end
			end else if (!ack) begin
				// Ack gone low, transfer complete
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	// Payload held for the whole transfer, response taken as ack rises
	always_ff @(posedge clk) begin
		if (start && !busy) begin
			req_payload <= payload;
		end
		if (req && ack) begin
			response <= ack_response;
		end
	end

	a_payload_stable: assert property (@(posedge clk) disable iff (mem_read_ready_stor_reset)
		req && $past(req) |-> $stable(req_payload));

	a_req_after_ack_low: assert property (@(posedge clk) disable iff (mem_read_ready_stor_reset)
		$rose(req) |-> !ack);

	a_start_when_idle: assert property (@(posedge clk) disable iff (mem_read_ready_stor_reset)
		start |-> !busy);

endmodule

`default_nettype wire

// ==== src/instr_sequencer.sv ====
// Instruction sequencer: program counter, fetch over the program port and decode of one instruction
`default_nettype none

module instr_sequencer (
	input  logic                clk,
	input  logic                mem_read_ready_stor_reset,
	output logic                fetch_req,
	output cpu_pkg::word_t      fetch_addr,
	input  logic                fetch_ack,
	input  cpu_pkg::word_t      fetch_data,
	output logic                exec_start,
	output cpu_pkg::opcode_t    op,
	output cpu_pkg::reg_addr_t  from_sel,
	output cpu_pkg::reg_addr_t  to_sel,
	output cpu_pkg::reg_addr_t  cond_sel,
	output cpu_pkg::word_t      set_value,
	input  logic                exec_done,
	output logic                halted
);

	cpu_pkg::seq_state_t state;
	cpu_pkg::word_t      pc;
	cpu_pkg::word_t      ir;

	// Set while a fetch transfer is outstanding
	logic           fetch_issued;
	logic           fetch_start;
	logic           fetch_done;
	cpu_pkg::word_t fetch_payload;
	cpu_pkg::word_t fetch_word;
	logic           stop_op;

	// Field split of the held instruction
	assign op       = cpu_pkg::opcode_t'(ir[cpu_pkg::op_field_lsb +: 4]);
	assign from_sel = ir[cpu_pkg::from_field_lsb +: 4];
	assign to_sel   = ir[cpu_pkg::to_field_lsb +: 4];
	assign cond_sel = ir[cpu_pkg::cond_field_lsb +: 4];

	// BUS is treated like HALT
	assign stop_op = (op == cpu_pkg::halt) || (op == cpu_pkg::bus);

	assign fetch_start = !fetch_issued &&
		((state == cpu_pkg::fetch) || (state == cpu_pkg::set_fetch));

	// SET operand word sits right after the instruction
	assign fetch_payload = (state == cpu_pkg::set_fetch) ? pc + 16'd1 : pc;

	assign exec_start = (state == cpu_pkg::decode) && !stop_op;
	assign halted     = (state == cpu_pkg::halted);

	four_phase_requester #(
		.payload_t  (cpu_pkg::word_t),
		.response_t (cpu_pkg::word_t)
	) u_fetch_requester (
		.clk                       (clk),
		.mem_read_ready_stor_reset (mem_read_ready_stor_reset),
		.start                     (fetch_start),
		.payload                   (fetch_payload),
		.req                       (fetch_req),
		.req_payload               (fetch_addr),
		.ack                       (fetch_ack),
		.ack_response              (fetch_data),
		.done                      (fetch_done),
		.response                  (fetch_word)
	);

	always_ff @(posedge clk) begin
		if (mem_read_ready_stor_reset) begin
			state <= cpu_pkg::fetch;
			pc <= '0;
			fetch_issued <= 1'b0;
		end else begin
			if (fetch_start) begin
				fetch_issued <= 1'b1;
			end else if (fetch_done) begin
				fetch_issued <= 1'b0;
			end

			case (state)
				cpu_pkg::fetch: begin
					if (fetch_done) begin
						if (fetch_word[cpu_pkg::op_field_lsb +: 4] == cpu_pkg::set) begin
							state <= cpu_pkg::set_fetch;
						end else begin
							state <= cpu_pkg::decode;
						end
					end
				end
				cpu_pkg::set_fetch: begin
					if (fetch_done) begin
						state <= cpu_pkg::decode;
					end
				end
				cpu_pkg::decode: begin
					state <= stop_op ? cpu_pkg::halted : cpu_pkg::execute;
				end
				cpu_pkg::execute: begin
					if (exec_done) begin
						state <= cpu_pkg::writeback;
					end
				end
				cpu_pkg::writeback: begin
					// Skip the operand word after SET
					pc <= (op == cpu_pkg::set) ? pc + 16'd2 : pc + 16'd1;
					state <= cpu_pkg::fetch;
				end
				cpu_pkg::halted: begin
					state <= cpu_pkg::halted;
				end
				default: state <= cpu_pkg::fetch;
			endcase
		end
	end

	// Instruction and SET operand registers
	always_ff @(posedge clk) begin
		if (fetch_done && state == cpu_pkg::fetch) begin
			ir <= fetch_word;
		end
		if (fetch_done && state == cpu_pkg::set_fetch) begin
			set_value <= fetch_word;
		end
	end

	// Execute unit idle when a new instruction starts
	a_start_exec_idle: assert property (@(posedge clk) disable iff (mem_read_ready_stor_reset)
		exec_start |-> !exec_done);

endmodule

`default_nettype wire

// ==== src/register_file.sv ====
// General register file with two combinational read ports and one write port for results
`default_nettype none

module register_file (
	input  logic               clk,
	input  logic               mem_read_ready_stor_reset,
	input  cpu_pkg::reg_addr_t read_a_sel,
	input  cpu_pkg::reg_addr_t read_b_sel,
	output cpu_pkg::word_t     read_a,
	output cpu_pkg::word_t     read_b,
	input  logic               write_en,
	input  cpu_pkg::reg_addr_t write_sel,
	input  cpu_pkg::word_t     write_data
);

	cpu_pkg::word_t regs [cpu_pkg::num_regs];

	// from operand and cond operand
	assign read_a = regs[read_a_sel];
	assign read_b = regs[read_b_sel];

	always_ff @(posedge clk) begin
		if (mem_read_ready_stor_reset) begin
			for (int i = 0; i < cpu_pkg::num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[write_sel] <= write_data;
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb_cpu.sv ====
// Testbench for cpu_top: memory models, directed program tests, watchdog and a closing summary
`default_nettype none

module tb_cpu;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int clk_period = 40;
	localparam int drive_delay = 1;
	localparam int reset_cycles = 16;
	localparam int max_prog_len = 80;
	localparam int max_cycles_per_instr = 40;
	localparam int num_runs = 7;
	localparam int watchdog_ns =
		num_runs * (reset_cycles + max_prog_len * max_cycles_per_instr) * clk_period;

	logic           clk = 1'b0;
	logic           mem_read_ready_stor_reset;
	logic           fetch_req;
	cpu_pkg::word_t fetch_addr;
	logic           fetch_ack;
	cpu_pkg::word_t fetch_data;
	logic           mem_req;
	logic           mem_we;
	cpu_pkg::word_t mem_addr;
	cpu_pkg::word_t mem_wdata;
	logic           mem_ack;
	cpu_pkg::word_t mem_rdata;
	logic           halted;

	cpu_pkg::word_t prog [256];
	cpu_pkg::word_t dmem [256];
	cpu_pkg::word_t fetch_log [$];
	cpu_pkg::word_t wr_addr_log [$];
	cpu_pkg::word_t wr_data_log [$];
	cpu_pkg::word_t exp_addr_log [$];
	cpu_pkg::word_t exp_data_log [$];
	int             prog_len;
	int             error_count = 0;
	int             tests_passed = 0;
	int             tests_failed = 0;

	cpu_top dut (
		.clk                       (clk),
		.mem_read_ready_stor_reset (mem_read_ready_stor_reset),
		.fetch_req                 (fetch_req),
		.fetch_addr                (fetch_addr),
		.fetch_ack                 (fetch_ack),
		.fetch_data                (fetch_data),
		.mem_req                   (mem_req),
		.mem_we                    (mem_we),
		.mem_addr                  (mem_addr),
		.mem_wdata                 (mem_wdata),
		.mem_ack                   (mem_ack),
		.mem_rdata                 (mem_rdata),
		.halted                    (halted)
	);

	always #(clk_period / 2) clk = ~clk;

	// Program memory, answers each fetch after 0 to 5 idle cycles
	initial begin : fetch_responder
		int unsigned delay;
		forever begin
			@(posedge clk);
			if (fetch_req === 1'b1 && !mem_read_ready_stor_reset) begin
				delay = $urandom_range(5, 0);
				repeat (delay) @(posedge clk);
				#(drive_delay);
				fetch_log.push_back(fetch_addr);
				fetch_data = prog[fetch_addr[7:0]];
				fetch_ack = 1'b1;
				do @(posedge clk); while (fetch_req);
				#(drive_delay);
				fetch_ack = 1'b0;
			end
		end
	end

	// Data memory, records every write
	initial begin : data_responder
		int unsigned delay;
		forever begin
			@(posedge clk);
			if (mem_req === 1'b1 && !mem_read_ready_stor_reset) begin
				delay = $urandom_range(5, 0);
				repeat (delay) @(posedge clk);
				#(drive_delay);
				if (mem_we) begin
					dmem[mem_addr[7:0]] = mem_wdata;
					wr_addr_log.push_back(mem_addr);
					wr_data_log.push_back(mem_wdata);
				end else begin
					mem_rdata = dmem[mem_addr[7:0]];
				end
				mem_ack = 1'b1;
				do @(posedge clk); while (mem_req);
				#(drive_delay);
				mem_ack = 1'b0;
			end
		end
	end

	initial begin : watchdog
		#(watchdog_ns);
		$display("Timeout: the run did not finish within %0d ns", watchdog_ns);
		$display("ERRORS FOUND");
		$finish;
	end

	task automatic report_error(string msg);
		$display("[ERROR] %0t ns: %s", $time, msg);
		error_count++;
	endtask

	task automatic report_problem(string msg);
		$display("Problem at %0t ns: %s", $time, msg);
		error_count++;
	endtask

	// Instruction word, cond in the top nibble and opcode in the bottom one
	function automatic cpu_pkg::word_t encode(cpu_pkg::opcode_t op, int from_reg, int to_reg,
		int cond_reg);
		return {4'(cond_reg), 4'(to_reg), 4'(from_reg), op};
	endfunction

	// Reference results of the ALU opcodes
	function automatic cpu_pkg::word_t alu_model(cpu_pkg::opcode_t op, cpu_pkg::word_t a,
		cpu_pkg::word_t b);
		logic [31:0]    product;
		cpu_pkg::word_t shifted;
		product = 32'(a) * 32'(b);
		shifted = a;
		// One bit per step, left when the high byte of b is nonzero
		for (int i = 0; i < int'(b[7:0]); i++) begin
			shifted = (b[15:8] != 8'd0) ? {shifted[14:0], 1'b0} : {1'b0, shifted[15:1]};
		end
		case (op)
			cpu_pkg::alu_and:  return a & b;
			cpu_pkg::alu_or:   return a | b;
			cpu_pkg::alu_xor:  return a ^ b;
			cpu_pkg::alu_add:  return a + b;
			cpu_pkg::alu_shft: return shifted;
			cpu_pkg::alu_mul:  return product[15:0];
			cpu_pkg::alu_gt:   return (a > b) ? 16'hFFFF : 16'h0000;
			cpu_pkg::alu_eq:   return (a == b) ? 16'hFFFF : 16'h0000;
			default:           return 16'h0000;
		endcase
	endfunction

	task automatic start_program();
		prog_len = 0;
		exp_addr_log.delete();
		exp_data_log.delete();
		for (int i = 0; i < 256; i++) begin
			prog[8'(i)] = '0;
		end
	endtask

	task automatic emit(cpu_pkg::word_t w);
		prog[8'(prog_len)] = w;
		prog_len++;
	endtask

	task automatic emit_set(int r, cpu_pkg::word_t value);
		emit(encode(cpu_pkg::set, 0, r, 0));
		emit(value);
	endtask

	task automatic expect_write(cpu_pkg::word_t addr, cpu_pkg::word_t data);
		exp_addr_log.push_back(addr);
		exp_data_log.push_back(data);
	endtask

	// Reset for 16 cycles, outputs must stay low while it is held
	task automatic reset_dut();
		@(posedge clk);
		#(drive_delay);
		mem_read_ready_stor_reset = 1'b1;
		for (int i = 0; i < reset_cycles; i++) begin
			@(posedge clk);
			if (i > 0 && (fetch_req !== 1'b0 || mem_req !== 1'b0 || halted !== 1'b0)) begin
				report_error("fetch_req, mem_req or halted is not low during reset");
			end
		end
		fetch_log.delete();
		wr_addr_log.delete();
		wr_data_log.delete();
		for (int i = 0; i < 256; i++) begin
			dmem[8'(i)] = {8'(i) ^ 8'h3C, ~8'(i)};
		end
		#(drive_delay);
		mem_read_ready_stor_reset = 1'b0;
	endtask

	task automatic run_until_halted();
		while (halted !== 1'b1) begin
			@(posedge clk);
		end
	endtask

	task automatic check_fetch_sequence(int n);
		if (fetch_log.size() != n) begin
			report_problem($sformatf("expected %0d fetches but saw %0d", n, fetch_log.size()));
		end else begin
			foreach (fetch_log[i]) begin
				if (fetch_log[i] !== 16'(i)) begin
					report_error($sformatf("fetch %0d address %h, expected %h", i,
						fetch_log[i], 16'(i)));
				end
			end
		end
	endtask

	task automatic check_writes();
		if (wr_addr_log.size() != exp_addr_log.size()) begin
			report_problem($sformatf("expected %0d data writes but saw %0d",
				exp_addr_log.size(), wr_addr_log.size()));
		end else begin
			foreach (exp_addr_log[i]) begin
				if (wr_addr_log[i] !== exp_addr_log[i]) begin
					report_error($sformatf("write %0d address %h, expected %h", i,
						wr_addr_log[i], exp_addr_log[i]));
				end
				if (wr_data_log[i] !== exp_data_log[i]) begin
					report_error($sformatf("write %0d data %h, expected %h", i,
						wr_data_log[i], exp_data_log[i]));
				end
			end
		end
	endtask

	task automatic finish_test(string name, int errors_before);
		if (error_count == errors_before) begin
			tests_passed++;
			$display("Test %s passed", name);
		end else begin
			tests_failed++;
			$display("Test %s failed with %0d errors", name, error_count - errors_before);
		end
	endtask

	task automatic test_reset();
		int errors_before;
		errors_before = error_count;
		start_program();
		emit_set(1, 16'h1234);
		emit(encode(cpu_pkg::halt, 0, 0, 0));
		reset_dut();
		@(posedge clk);
		if (fetch_req !== 1'b0 || mem_req !== 1'b0 || halted !== 1'b0) begin
			report_error("fetch_req, mem_req or halted is not low right after reset");
		end
		run_until_halted();
		check_fetch_sequence(3);
		finish_test("reset", errors_before);
	endtask

	task automatic test_set_memw();
		int             errors_before;
		cpu_pkg::word_t addr;
		cpu_pkg::word_t data;
		errors_before = error_count;
		addr = 16'($urandom_range(255, 0));
		data = 16'($urandom);
		start_program();
		emit_set(1, addr);
		emit_set(2, data);
		emit(encode(cpu_pkg::memw, 1, 0, 2));
		emit(encode(cpu_pkg::halt, 0, 0, 0));
		expect_write(addr, data);
		reset_dut();
		run_until_halted();
		// SET operands are skipped, so fetches stay in address order
		check_fetch_sequence(6);
		check_writes();
		finish_test("set_memw", errors_before);
	endtask

	task automatic test_alu();
		int               errors_before;
		cpu_pkg::opcode_t op;
		cpu_pkg::word_t   a;
		cpu_pkg::word_t   b;
		errors_before = error_count;
		start_program();
		for (int k = 0; k < 8; k++) begin
			op = cpu_pkg::opcode_t'(4'(8 + k));
			a = 16'($urandom);
			b = 16'($urandom);
			// Shift count 0 to 15, direction picked at random
			if (op == cpu_pkg::alu_shft) begin
				b = {7'd0, b[15], 4'd0, b[3:0]};
			end
			if (op == cpu_pkg::alu_eq && b[0]) begin
				b = a;
			end
			emit_set(1, a);
			emit_set(2, b);
			emit(encode(op, 1, 3, 2));
			emit_set(4, 16'(32 + k));
			emit(encode(cpu_pkg::memw, 4, 0, 3));
			expect_write(16'(32 + k), alu_model(op, a, b));
		end
		emit(encode(cpu_pkg::halt, 0, 0, 0));
		reset_dut();
		run_until_halted();
		check_writes();
		finish_test("alu", errors_before);
	endtask

	task automatic test_cond_moves();
		int             errors_before;
		cpu_pkg::word_t v;
		errors_before = error_count;
		v = 16'($urandom) | 16'h0001;
		start_program();
		emit_set(1, v);
		emit_set(2, 16'h0000);
		emit_set(3, 16'h0005);
		// Markers that an untaken move must leave in place
		emit_set(5, 16'h5A5A);
		emit_set(7, 16'hA5A5);
		emit(encode(cpu_pkg::movnz, 1, 4, 3));
		emit(encode(cpu_pkg::movnz, 1, 5, 2));
		emit(encode(cpu_pkg::movez, 1, 6, 2));
		emit(encode(cpu_pkg::movez, 1, 7, 3));
		emit(encode(cpu_pkg::mov, 1, 8, 0));
		for (int r = 4; r <= 8; r++) begin
			emit_set(9, 16'(64 + r));
			emit(encode(cpu_pkg::memw, 9, 0, r));
			expect_write(16'(64 + r), (r == 5) ? 16'h5A5A : (r == 7) ? 16'hA5A5 : v);
		end
		emit(encode(cpu_pkg::halt, 0, 0, 0));
		reset_dut();
		run_until_halted();
		check_writes();
		finish_test("cond_moves", errors_before);
	endtask

	task automatic test_memr();
		int             errors_before;
		cpu_pkg::word_t src_addr [4];
		cpu_pkg::word_t src_data [4];
		errors_before = error_count;
		start_program();
		for (int k = 0; k < 4; k++) begin
			src_addr[k] = 16'(128 + 16 * k + int'($urandom_range(15, 0)));
			src_data[k] = 16'($urandom);
			emit_set(1, src_addr[k]);
			emit(encode(cpu_pkg::memr, 1, 2, 0));
			emit_set(3, 16'(192 + k));
			emit(encode(cpu_pkg::memw, 3, 0, 2));
			expect_write(16'(192 + k), src_data[k]);
		end
		emit(encode(cpu_pkg::halt, 0, 0, 0));
		reset_dut();
		// Preload after the reset fill, before the first MEMR can run
		for (int k = 0; k < 4; k++) begin
			dmem[src_addr[k][7:0]] = src_data[k];
		end
		run_until_halted();
		check_writes();
		finish_test("memr", errors_before);
	endtask

	task automatic test_halt_bus();
		int errors_before;
		bit fetched_again;
		errors_before = error_count;
		for (int k = 0; k < 2; k++) begin
			start_program();
			emit_set(1, 16'h00FF);
			emit(encode((k == 0) ? cpu_pkg::halt : cpu_pkg::bus, 0, 0, 0));
			reset_dut();
			run_until_halted();
			check_fetch_sequence(3);
			fetched_again = 1'b0;
			repeat (20) begin
				@(posedge clk);
				if (fetch_req !== 1'b0 || halted !== 1'b1) begin
					fetched_again = 1'b1;
				end
			end
			if (fetched_again) begin
				report_problem("the core fetched again or left the halted state");
			end
			if (wr_addr_log.size() != 0) begin
				report_problem("a stopped program wrote to data memory");
			end
		end
		finish_test("halt_bus", errors_before);
	endtask

	initial begin
		void'($urandom(34));
		mem_read_ready_stor_reset = 1'b1;
		fetch_ack = 1'b0;
		fetch_data = '0;
		mem_ack = 1'b0;
		mem_rdata = '0;
		test_reset();
		test_set_memw();
		test_alu();
		test_cond_moves();
		test_memr();
		test_halt_bus();
		$display("Tests passed: %0d, tests failed: %0d, failed checks: %0d",
			tests_passed, tests_failed, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/cpu_pkg.sv
src/four_phase_requester.sv
src/instr_sequencer.sv
src/execute_unit.sv
src/register_file.sv
src/cpu_top.sv
testbench/tb_cpu.sv
